//--- source/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // 4x4 feature map in row-major order
    localparam int FEAT_COUNT = 16;

    // 3x3 kernel in row-major order
    localparam int WEIGHT_COUNT = 9;

    // one load step per word
    localparam int LOAD_COUNT = FEAT_COUNT + WEIGHT_COUNT;

    // scratch layout
    localparam int FEAT_BASE = 0;
    localparam int WEIGHT_BASE = 16;

    // sequencer count with 0..24 in use
    typedef logic [4:0] cnt_t;

    // scratch address whose bit 5 the decoder leaves at 0
    typedef logic [5:0] addr_t;

    // one signed word
    typedef logic signed [7:0] data_t;

    // 9 products of -128 * -128 need 19 signed bits and 20 leave headroom
    typedef logic signed [19:0] acc_t;

endpackage

`default_nettype wire

//--- source/load_addr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module load_addr_decoder import conv_pkg::*; (
    input  cnt_t  cnt,
    output addr_t addr
);

    // inverted count bits shared by all product terms
    logic [4:0] cnt_n;

    // product terms, one group per address bit
    logic [3:0] product4;
    logic [6:0] product3;
    logic [4:0] product2;
    logic [7:0] product1;
    logic [6:0] product0;

    // partial sums, two halves per wide bit
    logic [1:0] sum3;
    logic [1:0] sum2;
    logic [1:0] sum1;
    logic [1:0] sum0;

    // low five address bits, bit 5 stays 0
    logic [4:0] sum;

    assign cnt_n = ~cnt;

    // addr[4] = 101-- | 100-0 | 011-1 | 11000
    assign product4[0] = cnt[4] & cnt_n[3] & cnt[2];
    assign product4[1] = cnt[4] & cnt_n[3] & cnt_n[2] & cnt_n[0];
    assign product4[2] = cnt_n[4] & cnt[3] & cnt[2] & cnt[0];
    assign product4[3] = cnt[4] & cnt[3] & cnt_n[2] & cnt_n[1] & cnt_n[0];
    assign sum[4] = |product4;

    // addr[3] = 001-0 | 00101 | 00111 | 0100- | 010-1 | 10011 | 11000
    assign product3[0] = cnt_n[4] & cnt_n[3] & cnt[2] & cnt_n[0];
    assign product3[1] = cnt_n[4] & cnt_n[3] & cnt[2] & cnt_n[1] & cnt[0];
    assign product3[2] = cnt_n[4] & cnt_n[3] & cnt[2] & cnt[1] & cnt[0];
    assign product3[3] = cnt_n[4] & cnt[3] & cnt_n[2] & cnt_n[1];
    assign product3[4] = cnt_n[4] & cnt[3] & cnt_n[2] & cnt[0];
    assign product3[5] = cnt[4] & cnt_n[3] & cnt_n[2] & cnt[1] & cnt[0];
    assign product3[6] = cnt[4] & cnt[3] & cnt_n[2] & cnt_n[1] & cnt_n[0];
    assign sum3[0] = |product3[3:0];
    assign sum3[1] = |product3[6:4];
    assign sum[3] = sum3[0] | sum3[1];

    // addr[2] = 00111 | 01--0 | 010-1 | 10001 | 101--
    assign product2[0] = cnt_n[4] & cnt_n[3] & cnt[2] & cnt[1] & cnt[0];
    assign product2[1] = cnt_n[4] & cnt[3] & cnt_n[0];
    assign product2[2] = cnt_n[4] & cnt[3] & cnt_n[2] & cnt[0];
    assign product2[3] = cnt[4] & cnt_n[3] & cnt_n[2] & cnt_n[1] & cnt[0];
    assign product2[4] = cnt[4] & cnt_n[3] & cnt[2];
    assign sum2[0] = |product2[2:0];
    assign sum2[1] = product2[3] | product2[4];
    assign sum[2] = sum2[0] | sum2[1];

    // addr[1] = -0-10 | 0-011 | 00101 | 0-110 | 010-1 | 100-0 | 10001 | 1011-
    assign product1[0] = cnt_n[3] & cnt[1] & cnt_n[0];
    assign product1[1] = cnt_n[4] & cnt_n[2] & cnt[1] & cnt[0];
    assign product1[2] = cnt_n[4] & cnt_n[3] & cnt[2] & cnt_n[1] & cnt[0];
    assign product1[3] = cnt_n[4] & cnt[2] & cnt[1] & cnt_n[0];
    assign product1[4] = cnt_n[4] & cnt[3] & cnt_n[2] & cnt[0];
    assign product1[5] = cnt[4] & cnt_n[3] & cnt_n[2] & cnt_n[0];
    assign product1[6] = cnt[4] & cnt_n[3] & cnt_n[2] & cnt_n[1] & cnt[0];
    assign product1[7] = cnt[4] & cnt_n[3] & cnt[2] & cnt[1];
    assign sum1[0] = |product1[3:0];
    assign sum1[1] = |product1[7:4];
    assign sum[1] = sum1[0] | sum1[1];

    // addr[0] = -0001 | 0-011 | 001-0 | 01-00 | 01-11 | 10010 | 101-1
    assign product0[0] = cnt_n[3] & cnt_n[2] & cnt_n[1] & cnt[0];
    assign product0[1] = cnt_n[4] & cnt_n[2] & cnt[1] & cnt[0];
    assign product0[2] = cnt_n[4] & cnt_n[3] & cnt[2] & cnt_n[0];
    assign product0[3] = cnt_n[4] & cnt[3] & cnt_n[1] & cnt_n[0];
    assign product0[4] = cnt_n[4] & cnt[3] & cnt[1] & cnt[0];
    assign product0[5] = cnt[4] & cnt_n[3] & cnt_n[2] & cnt[1] & cnt_n[0];
    assign product0[6] = cnt[4] & cnt_n[3] & cnt[2] & cnt[0];
    assign sum0[0] = |product0[3:0];
    assign sum0[1] = |product0[6:4];
    assign sum[0] = sum0[0] | sum0[1];

    // counts 25..31 hit no term and fall to address 0
    assign addr = {1'b0, sum};

    // the decoder never points past the last weight word
    // (checked once the count is driven)
    addr_range_chk: assert final (
        $isunknown(cnt) || addr <= addr_t'(WEIGHT_BASE + WEIGHT_COUNT - 1)
    ) else $error("load decoder address %0d beyond weight window", addr);

endmodule

`default_nettype wire

//--- source/load_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module load_sequencer import conv_pkg::*; #(
    parameter int STEPS = LOAD_COUNT
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output cnt_t cnt,
    output logic cnt_valid,
    output logic load_done,
    output logic busy
);

    typedef enum logic {
        S_IDLE,
        S_RUN
    } state_t;

    state_t state;

    // final load step this run
    logic last_cnt;

    assign last_cnt = (cnt == cnt_t'(STEPS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            cnt       <= '0;
            load_done <= 1'b0;
        end else begin
            // one-cycle pulse
            load_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    // start counts only when fully idle, done cycle included
                    if (start && !busy) begin
                        state <= S_RUN;
                        cnt   <= '0;
                    end
                end
                S_RUN: begin
                    if (last_cnt) begin
                        state     <= S_IDLE;
                        load_done <= 1'b1;
                    end else begin
                        cnt <= cnt + cnt_t'(1);
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // one valid count per cycle while running
    assign cnt_valid = (state == S_RUN);

    // cover the done cycle too, so busy has no gap before the engine takes over
    assign busy = cnt_valid | load_done;

    // counts past the last step must never reach the decoder
    cnt_range_chk: assert property (
        @(posedge clk) disable iff (rst)
        cnt_valid |-> cnt < cnt_t'(STEPS)
    ) else $error("load count %0d out of range", cnt);

endmodule

`default_nettype wire

//--- source/scratch_mem.sv
`timescale 1ns/10ps
`default_nettype none

module scratch_mem import conv_pkg::*; #(
    parameter int DEPTH = 32
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  data_t wr_data,
    input  logic  rd_en,
    input  addr_t rd_addr_in,
    output data_t rd_data,
    output logic  rd_valid,
    output addr_t rd_addr
);

    localparam int AW = $clog2(DEPTH);

    data_t mem [DEPTH];

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[AW-1:0]] <= wr_data;
        end
    end

    // registered read, address travels with the word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr_in[AW-1:0]];
            rd_addr <= rd_addr_in;
        end
    end

    // valid tracks the read one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // host writes must stay off the words the load is reading
    wr_rd_collision_chk: assert property (
        @(posedge clk) disable iff (rst)
        !(wr_en && rd_en && wr_addr == rd_addr_in)
    ) else $error("host write to address %0d during load read", wr_addr);

endmodule

`default_nettype wire

//--- source/operand_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module operand_buffer import conv_pkg::*; #(
    parameter type elem_t = data_t,
    parameter int  DEPTH  = FEAT_COUNT,
    parameter int  BASE   = FEAT_BASE
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    input  addr_t in_addr,
    input  elem_t in_data,
    output elem_t words [DEPTH]
);

    localparam int IW = $clog2(DEPTH);

    // position inside this window, wraps high for addresses below BASE
    addr_t offset;

    // word belongs to this buffer
    logic in_window;

    // store strobe
    logic store;

    assign offset    = in_addr - addr_t'(BASE);
    assign in_window = (offset < addr_t'(DEPTH));
    assign store     = in_valid & in_window;

    always_ff @(posedge clk) begin
        if (rst) begin
            // cleared so a run before any load gives zeros
            for (int i = 0; i < DEPTH; i++) begin
                words[i] <= '0;
            end
        end else if (store) begin
            words[offset[IW-1:0]] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- source/conv3x3_engine.sv
`timescale 1ns/10ps
`default_nettype none

module conv3x3_engine import conv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  go,
    input  data_t features [FEAT_COUNT],
    input  data_t weights [WEIGHT_COUNT],
    output acc_t  result,
    output logic  result_valid,
    output logic  done,
    output logic  busy
);

    // kernel tap, 0..8, also the weight index
    logic [3:0] k_idx;

    // kernel row and column of the current tap
    logic [1:0] k_row;
    logic [1:0] k_col;

    // output position, 2x2
    logic out_row;
    logic out_col;

    // tenth cycle of each output, no MAC
    logic emit;

    logic [1:0] feat_row;
    logic [3:0] feat_idx;
    logic signed [2*$bits(data_t)-1:0] prod;
    acc_t acc;

    // feature at (out_row + k_row, out_col + k_col) in the 4x4 map
    assign feat_row = {1'b0, out_row} + k_row;
    assign feat_idx = {feat_row, 2'b00} + {3'b000, out_col} + {2'b00, k_col};

    assign prod = features[feat_idx] * weights[k_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            result_valid <= 1'b0;
            done         <= 1'b0;
            emit         <= 1'b0;
            k_idx        <= '0;
            k_row        <= '0;
            k_col        <= '0;
            out_row      <= 1'b0;
            out_col      <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            done         <= 1'b0;
            if (!busy) begin
                if (go) begin
                    busy    <= 1'b1;
                    emit    <= 1'b0;
                    k_idx   <= '0;
                    k_row   <= '0;
                    k_col   <= '0;
                    out_row <= 1'b0;
                    out_col <= 1'b0;
                end
            end else if (emit) begin
                // output cycle, step to the next position in raster order
                emit         <= 1'b0;
                result_valid <= 1'b1;
                out_col      <= ~out_col;
                if (out_col) begin
                    out_row <= ~out_row;
                end
                if (out_row && out_col) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (k_idx == 4'd8) begin
                emit  <= 1'b1;
                k_idx <= '0;
                k_row <= '0;
                k_col <= '0;
            end else begin
                k_idx <= k_idx + 4'd1;
                if (k_col == 2'd2) begin
                    k_col <= '0;
                    k_row <= k_row + 2'd1;
                end else begin
                    k_col <= k_col + 2'd1;
                end
            end
        end
    end

    // single MAC, cleared at go and after each output
    always_ff @(posedge clk) begin
        if (!busy) begin
            acc <= '0;
        end else if (emit) begin
            result <= acc;
            acc    <= '0;
        end else begin
            acc <= acc + prod;
        end
    end

    // the top level holds start off while the engine runs
    go_while_busy_chk: assert property (
        @(posedge clk) disable iff (rst)
        go |-> !busy
    ) else $error("engine go arrived while busy");

endmodule

`default_nettype wire

//--- source/conv_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_top import conv_pkg::*; #(
    parameter int MEM_DEPTH = 32
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  data_t wr_data,
    input  logic  start,
    output logic  busy,
    output acc_t  result,
    output logic  result_valid,
    output logic  done
);

    cnt_t  cnt;
    logic  cnt_valid;
    logic  load_done;
    logic  seq_busy;
    logic  eng_busy;
    logic  start_ok;
    addr_t load_addr;
    data_t rd_data;
    logic  rd_valid;
    addr_t rd_addr;
    data_t feat_words [FEAT_COUNT];
    data_t weight_words [WEIGHT_COUNT];

    // a start during the compute phase must not reload the buffers
    assign start_ok = start & ~eng_busy;

    // high from start until the engine's done
    assign busy = seq_busy | eng_busy;

    load_sequencer #(
        .STEPS(LOAD_COUNT)
    ) u_load_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start_ok),
        .cnt       (cnt),
        .cnt_valid (cnt_valid),
        .load_done (load_done),
        .busy      (seq_busy)
    );

    load_addr_decoder u_load_addr_decoder (
        .cnt  (cnt),
        .addr (load_addr)
    );

    scratch_mem #(
        .DEPTH(MEM_DEPTH)
    ) u_scratch_mem (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (cnt_valid),
        .rd_addr_in (load_addr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr)
    );

    // both buffers see every read word, each keeps its own window
    operand_buffer #(
        .elem_t (data_t),
        .DEPTH  (FEAT_COUNT),
        .BASE   (FEAT_BASE)
    ) u_feat_buffer (
        .clk      (clk),
        .rst      (rst),
        .in_valid (rd_valid),
        .in_addr  (rd_addr),
        .in_data  (rd_data),
        .words    (feat_words)
    );

    operand_buffer #(
        .elem_t (data_t),
        .DEPTH  (WEIGHT_COUNT),
        .BASE   (WEIGHT_BASE)
    ) u_weight_buffer (
        .clk      (clk),
        .rst      (rst),
        .in_valid (rd_valid),
        .in_addr  (rd_addr),
        .in_data  (rd_data),
        .words    (weight_words)
    );

    conv3x3_engine u_conv3x3_engine (
        .clk          (clk),
        .rst          (rst),
        .go           (load_done),
        .features     (feat_words),
        .weights      (weight_words),
        .result       (result),
        .result_valid (result_valid),
        .done         (done),
        .busy         (eng_busy)
    );

endmodule

`default_nettype wire

//--- tests/conv_tb.sv
`timescale 1ns/10ps
`default_nettype none

module conv_tb import conv_pkg::*; ();

    // global bound of about 16 runs of 100 cycles plus margin
    localparam int TIMEOUT_CYCLES = 3000;

    // longest wait for done after one start
    localparam int RUN_LIMIT = 100;

    logic  clk;
    logic  rst;
    logic  wr_en;
    addr_t wr_addr;
    data_t wr_data;
    logic  start;
    logic  busy;
    acc_t  result;
    logic  result_valid;
    logic  done;

    // image held by the testbench that mirrors what goes into scratch
    data_t feat_img [FEAT_COUNT];
    data_t weight_img [WEIGHT_COUNT];

    // results gathered by the last run
    acc_t got [4];
    int   got_count;
    int   done_count;

    logic [15:0] lfsr = 16'd62289;
    int cycle_count = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_ok = 0;

    conv_top u_conv_top (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .start        (start),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // run stops here if a wait never ends
    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("run timed out after %0d cycles", cycle_count);
        $display("Testbench failed");
        $finish;
    end

    // taps of x^16 + x^14 + x^13 + x^11 + 1 with one bit per call
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic data_t random_word();
        data_t w;
        for (int b = 0; b < 8; b++) begin
            w[b] = lfsr_bit();
        end
        return w;
    endfunction

    // output (r,c) of a 3x3 valid convolution over the 4x4 map
    function automatic acc_t conv_ref(input int r, input int c);
        acc_t sum;
        sum = '0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                sum += acc_t'(feat_img[(r + i) * 4 + c + j]) * acc_t'(weight_img[i * 3 + j]);
            end
        end
        return sum;
    endfunction

    // host writes one word per cycle and ends on a falling edge
    task automatic write_image();
        for (int i = 0; i < FEAT_COUNT; i++) begin
            wr_en   = 1'b1;
            wr_addr = addr_t'(FEAT_BASE + i);
            wr_data = feat_img[i];
            @(negedge clk);
        end
        for (int j = 0; j < WEIGHT_COUNT; j++) begin
            wr_en   = 1'b1;
            wr_addr = addr_t'(WEIGHT_BASE + j);
            wr_data = weight_img[j];
            @(negedge clk);
        end
        wr_en = 1'b0;
    endtask

    // outputs that rest low while nothing runs
    task automatic expect_idle();
        if (busy !== 1'b0) begin
            $display("Mismatch busy expected 0x0 got 0x%h", busy);
            errors++;
        end
        if (result_valid !== 1'b0) begin
            $display("Mismatch result_valid expected 0x0 got 0x%h", result_valid);
            errors++;
        end
        if (done !== 1'b0) begin
            $display("Mismatch done expected 0x0 got 0x%h", done);
            errors++;
        end
    endtask

    // pulse start and take every result on its pulse until done
    task automatic run_and_collect(input bit extra_starts);
        int  cyc;
        bit  finished;
        got_count  = 0;
        done_count = 0;
        cyc        = 0;
        finished   = 1'b0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("Mismatch busy expected 0x1 got 0x%h after start", busy);
            errors++;
        end
        while (!finished && cyc < RUN_LIMIT) begin
            @(negedge clk);
            cyc++;
            // stray starts in the load phase and in the compute phase
            start = extra_starts && (cyc == 10 || cyc == 50);
            // busy holds from start until the cycle of done
            if (done !== 1'b1 && busy !== 1'b1) begin
                $display("Mismatch busy expected 0x1 got 0x%h at run cycle %0d", busy, cyc);
                errors++;
            end
            if (result_valid === 1'b1) begin
                if (got_count < 4) begin
                    got[got_count] = result;
                end
                got_count++;
            end
            if (done === 1'b1) begin
                done_count++;
                finished = 1'b1;
                if (result_valid !== 1'b1 || got_count != 4) begin
                    $display("done came with %0d results instead of on the fourth", got_count);
                    errors++;
                end
            end
        end
        start = 1'b0;
        if (!finished) begin
            $display("no done within %0d cycles of start", RUN_LIMIT);
            errors++;
        end
        // nothing more should fire in the quiet cycles after done
        repeat (6) begin
            @(negedge clk);
            expect_idle();
        end
    endtask

    task automatic compare_results(input string tag);
        acc_t expected;
        for (int k = 0; k < 4; k++) begin
            expected = conv_ref(k / 2, k % 2);
            if (got[k] !== expected) begin
                $display("Mismatch result %s out %0d expected 0x%05h got 0x%05h",
                         tag, k, expected, got[k]);
                errors++;
            end
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic check_reset_state();
        int e0;
        e0 = errors;
        repeat (20) begin
            @(negedge clk);
            expect_idle();
        end
        close_test("reset_state", e0);
    endtask

    // with only the centre tap each output is the centre feature of its window
    task automatic check_centre_weight();
        int e0;
        e0 = errors;
        for (int i = 0; i < FEAT_COUNT; i++) begin
            feat_img[i] = data_t'(i);
        end
        for (int j = 0; j < WEIGHT_COUNT; j++) begin
            weight_img[j] = (j == 4) ? data_t'(1) : data_t'(0);
        end
        write_image();
        run_and_collect(1'b0);
        compare_results("centre");
        close_test("centre_weight", e0);
    endtask

    // one-hot kernel at every tap over distinct signed features
    task automatic sweep_one_hot_weight();
        int e0;
        e0 = errors;
        for (int i = 0; i < FEAT_COUNT; i++) begin
            feat_img[i] = data_t'(i * 7 - 50);
        end
        for (int p = 0; p < WEIGHT_COUNT; p++) begin
            for (int j = 0; j < WEIGHT_COUNT; j++) begin
                weight_img[j] = (j == p) ? data_t'(1) : data_t'(0);
            end
            write_image();
            run_and_collect(1'b0);
            compare_results($sformatf("tap%0d", p));
        end
        close_test("weight_sweep", e0);
    endtask

    task automatic compare_random_data();
        int e0;
        e0 = errors;
        for (int n = 0; n < 3; n++) begin
            for (int i = 0; i < FEAT_COUNT; i++) begin
                feat_img[i] = random_word();
            end
            for (int j = 0; j < WEIGHT_COUNT; j++) begin
                weight_img[j] = random_word();
            end
            write_image();
            run_and_collect(1'b0);
            compare_results($sformatf("random%0d", n));
        end
        // largest positive sum is 9 * 16384
        for (int i = 0; i < FEAT_COUNT; i++) begin
            feat_img[i] = data_t'(-128);
        end
        for (int j = 0; j < WEIGHT_COUNT; j++) begin
            weight_img[j] = data_t'(-128);
        end
        write_image();
        run_and_collect(1'b0);
        compare_results("min_words");
        close_test("random_data", e0);
    endtask

    // second start reuses the loaded scratch and must ignore stray starts
    task automatic repeat_same_image();
        int e0;
        acc_t first [4];
        e0 = errors;
        for (int i = 0; i < FEAT_COUNT; i++) begin
            feat_img[i] = random_word();
        end
        for (int j = 0; j < WEIGHT_COUNT; j++) begin
            weight_img[j] = random_word();
        end
        write_image();
        run_and_collect(1'b0);
        compare_results("first_run");
        first = got;
        run_and_collect(1'b1);
        compare_results("second_run");
        if (done_count != 1) begin
            $display("done seen %0d times in one run", done_count);
            errors++;
        end
        for (int k = 0; k < 4; k++) begin
            if (got[k] !== first[k]) begin
                $display("Mismatch result repeat out %0d expected 0x%05h got 0x%05h",
                         k, first[k], got[k]);
                errors++;
            end
        end
        close_test("repeated_run", e0);
    endtask

    initial begin
        rst     = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        start   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_reset_state();
        check_centre_weight();
        sweep_one_hot_weight();
        compare_random_data();
        repeat_same_image();

        $display("tests run %0d, ok %0d, failing %0d, check errors %0d",
                 tests_run, tests_ok, tests_run - tests_ok, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/conv_pkg.sv
source/load_addr_decoder.sv
source/load_sequencer.sv
source/scratch_mem.sv
source/operand_buffer.sv
source/conv3x3_engine.sv
source/conv_top.sv
tests/conv_tb.sv
